//--- uart_status_flags.f
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_rx_fifo.sv
source/uart_status_flags.sv
verif/tb_clock_gen.sv
verif/uart_status_flags_properties.sv
verif/uart_status_flags_tb.sv

//--- Bender.yml
package:
  name: uart_status_flags

sources:
  # design
  - files:
      - source/uart_pkg.sv
      - source/uart_tx.sv
      - source/uart_rx.sv
      - source/uart_rx_fifo.sv
      - source/uart_status_flags.sv

  # testbench
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/uart_status_flags_properties.sv
      - verif/uart_status_flags_tb.sv

//--- verif/uart_status_flags_tb.sv
// uart testbench covering transmit frames, receive and pop, overrun, break and status clear
`timescale 1ns/1ps

module uart_status_flags_tb;

  localparam int n_tx = 8;
  localparam int n_rx = 4;
  localparam int total_frames = n_tx + n_rx + (uart_pkg::fifo_depth + 1) + 1;
  localparam int timeout_cycles = total_frames * (uart_pkg::frame_bits + 4) + 200;

  // expected serial frame plus its break marker
  typedef struct packed {
    logic [uart_pkg::frame_bits-1:0] bits;
    logic                            brk;
  } exp_frame_t;

  logic                        clk;
  logic                        rst_n;
  logic                        tx_start;
  logic [uart_pkg::data_w-1:0] tx_data;
  logic                        rx_in;
  logic                        rx_pop;
  logic                        status_clear;
  logic                        tx_out;
  logic                        tx_idle;
  logic                        tx_done;
  logic                        rx_idle;
  logic [uart_pkg::data_w-1:0] rx_data;
  logic                        rx_ready;
  logic                        rx_error;
  uart_pkg::status_t           status_flags;

  logic [31:0]         lfsr_state = 32'h06aff983;
  logic                tx_exp_q[$];
  uart_pkg::rx_frame_t rx_model_q[$];
  logic                model_overrun = 1'b0;
  logic                model_brk = 1'b0;
  int                  check_count = 0;
  int                  mismatch_count = 0;
  int                  failure_count = 0;

  tb_clock_gen clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_status_flags dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .tx_start     (tx_start),
    .tx_data      (tx_data),
    .rx_in        (rx_in),
    .rx_pop       (rx_pop),
    .status_clear (status_clear),
    .tx_out       (tx_out),
    .tx_idle      (tx_idle),
    .tx_done      (tx_done),
    .rx_idle      (rx_idle),
    .rx_data      (rx_data),
    .rx_ready     (rx_ready),
    .rx_error     (rx_error),
    .status_flags (status_flags)
  );

  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    logic fb;
    // taps 32, 22, 2, 1
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_random_byte(output logic [uart_pkg::data_w-1:0] b);
    for (int i = 0; i < uart_pkg::data_w; i++) begin
      lfsr_state = next_lfsr(lfsr_state);
      b[i] = lfsr_state[0];
    end
  endtask

  // frame is start 0, data lsb first, then stop
  // break means zero data with a low stop
  function automatic exp_frame_t build_frame(input logic [uart_pkg::data_w-1:0] b,
                                             input logic stop);
    exp_frame_t f;
    f.bits = {stop, b, 1'b0};
    f.brk  = (b == '0) && !stop;
    return f;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    mismatch_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("at %0t: %s", $time, msg);
    failure_count++;
  endtask

  task automatic print_counts();
    $display("checks: %0d, mismatches: %0d, other failures: %0d",
             check_count, mismatch_count, failure_count);
  endtask

  // FIFO model that drops on full and keeps sticky flags
  task automatic model_push(input exp_frame_t f);
    uart_pkg::rx_frame_t e;
    e.data = f.bits[uart_pkg::data_w:1];
    e.brk  = f.brk;
    if (f.brk) begin
      model_brk = 1'b1;
    end
    if (rx_model_q.size() == uart_pkg::fifo_depth) begin
      model_overrun = 1'b1;
    end else begin
      rx_model_q.push_back(e);
    end
  endtask

  task automatic check_reset_state();
    check_count++;
    if (tx_out !== 1'b1 || tx_idle !== 1'b1 || rx_idle !== 1'b1) begin
      report_mismatch($sformatf("idle levels after reset tx_out %b tx_idle %b rx_idle %b",
                                tx_out, tx_idle, rx_idle));
    end
    if (status_flags !== 4'b0100) begin
      report_mismatch($sformatf("status_flags %b after reset, expected 0100", status_flags));
    end
    if (tx_done !== 1'b0 || rx_ready !== 1'b0 || rx_error !== 1'b0) begin
      report_mismatch($sformatf("tx_done %b rx_ready %b rx_error %b after reset",
                                tx_done, rx_ready, rx_error));
    end
  endtask

  task automatic check_status();
    uart_pkg::status_t exp;
    exp.fifo_full  = (rx_model_q.size() == uart_pkg::fifo_depth);
    exp.fifo_empty = (rx_model_q.size() == 0);
    exp.overrun    = model_overrun;
    exp.brk        = model_brk;
    check_count++;
    if (status_flags !== exp) begin
      report_mismatch($sformatf("status_flags %b, expected %b", status_flags, exp));
    end
    if (rx_ready !== !exp.fifo_empty) begin
      report_mismatch($sformatf("rx_ready %b, expected %b", rx_ready, !exp.fifo_empty));
    end
    if (rx_error !== (exp.overrun || exp.brk)) begin
      report_mismatch($sformatf("rx_error %b, expected %b", rx_error,
                                exp.overrun || exp.brk));
    end
  endtask

  // a second start in mid-frame carries busy_b and must be ignored
  task automatic send_tx_byte(input logic [uart_pkg::data_w-1:0] b,
                              input logic [uart_pkg::data_w-1:0] busy_b);
    exp_frame_t f;
    int         waited;
    f = build_frame(b, 1'b1);
    if (!tx_idle) begin
      report_failure("transmitter still busy when a new frame was due");
    end
    tx_data  = b;
    tx_start = 1'b1;
    @(posedge clk);
    for (int i = 0; i < uart_pkg::frame_bits; i++) begin
      tx_exp_q.push_back(f.bits[i]);
    end
    @(negedge clk);
    tx_start = 1'b0;
    for (int i = 2; i <= uart_pkg::frame_bits; i++) begin
      @(negedge clk);
      if (tx_done) begin
        report_failure("tx_done pulsed before the stop bit ended");
      end
      if (tx_idle) begin
        report_mismatch("tx_idle high during a frame");
      end
      if (i == 4) begin
        tx_data  = busy_b;
        tx_start = 1'b1;
      end else if (i == 5) begin
        tx_start = 1'b0;
      end
    end
    waited = 0;
    while (!tx_done && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!tx_done) begin
      report_failure("tx_done never pulsed after the frame");
    end else begin
      if (!tx_idle) begin
        report_mismatch("tx_idle low in the tx_done cycle");
      end
      @(negedge clk);
      if (tx_done) begin
        report_failure("tx_done stayed high for more than one cycle");
      end
    end
  endtask

  task automatic send_rx_frame(input logic [uart_pkg::data_w-1:0] b, input logic stop);
    exp_frame_t f;
    f = build_frame(b, stop);
    for (int i = 0; i < uart_pkg::frame_bits - 1; i++) begin
      rx_in = f.bits[i];
      @(negedge clk);
    end
    rx_in = f.bits[uart_pkg::frame_bits-1];
    @(posedge clk);
    model_push(f);
    @(negedge clk);
    rx_in = 1'b1;
  endtask

  // receiver back to idle, then one cycle for the FIFO write
  task automatic wait_rx_settled();
    int waited;
    waited = 0;
    if (rx_idle) begin
      report_mismatch("rx_idle high while a frame is being received");
    end
    while (!rx_idle && waited < uart_pkg::frame_bits + 3) begin
      @(negedge clk);
      waited++;
    end
    if (!rx_idle) begin
      report_failure("receiver did not return to idle after a frame");
    end else begin
      @(negedge clk);
    end
  endtask

  task automatic pop_byte();
    int waited;
    waited = 0;
    while (!rx_ready && waited < uart_pkg::frame_bits + 3) begin
      @(negedge clk);
      waited++;
    end
    if (!rx_ready) begin
      report_failure("rx_ready never rose, nothing to pop");
    end else begin
      rx_pop = 1'b1;
      @(posedge clk);
      void'(rx_model_q.pop_front());
      @(negedge clk);
      rx_pop = 1'b0;
    end
  endtask

  task automatic pop_on_empty();
    if (rx_ready) begin
      report_failure("FIFO not empty before the pop on empty");
    end
    rx_pop = 1'b1;
    @(negedge clk);
    rx_pop = 1'b0;
  endtask

  task automatic clear_status();
    status_clear = 1'b1;
    @(posedge clk);
    model_overrun = 1'b0;
    model_brk     = 1'b0;
    @(negedge clk);
    status_clear = 1'b0;
  endtask

  // serial line and FIFO head against the expected queues
  always @(negedge clk) begin : compare_outputs
    logic exp_bit;
    if (rst_n) begin
      if (tx_exp_q.size() > 0) begin
        exp_bit = tx_exp_q.pop_front();
        check_count++;
        if (tx_out !== exp_bit) begin
          report_mismatch($sformatf("tx_out %b, expected %b", tx_out, exp_bit));
        end
      end else if (tx_out !== 1'b1) begin
        report_mismatch("tx_out low outside a frame");
      end
      if (rx_ready) begin
        if (rx_model_q.size() == 0) begin
          report_failure("rx_ready high while no byte was expected");
        end else begin
          check_count++;
          if (rx_data !== rx_model_q[0].data) begin
            report_mismatch($sformatf("rx_data %h, expected %h", rx_data,
                                      rx_model_q[0].data));
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    print_counts();
    $display("Test failed");
    $finish;
  end

  initial begin : run_tests
    logic [uart_pkg::data_w-1:0] b;
    logic [uart_pkg::data_w-1:0] other;
    tx_start     = 1'b0;
    tx_data      = '0;
    rx_in        = 1'b1;
    rx_pop       = 1'b0;
    status_clear = 1'b0;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_reset_state();

    for (int i = 0; i < n_tx; i++) begin
      take_random_byte(b);
      take_random_byte(other);
      send_tx_byte(b, other);
    end

    // receive, then drain in order
    for (int i = 0; i < n_rx; i++) begin
      take_random_byte(b);
      send_rx_frame(b, 1'b1);
      wait_rx_settled();
      check_status();
    end
    for (int i = 0; i < n_rx; i++) begin
      pop_byte();
      check_status();
    end
    pop_on_empty();
    check_status();

    // one frame more than the FIFO holds
    for (int i = 0; i < uart_pkg::fifo_depth + 1; i++) begin
      take_random_byte(b);
      send_rx_frame(b, 1'b1);
      wait_rx_settled();
      check_status();
    end
    for (int i = 0; i < uart_pkg::fifo_depth; i++) begin
      pop_byte();
      check_status();
    end

    // overrun cleared first so that only the break drives rx_error
    clear_status();
    check_status();

    send_rx_frame('0, 1'b0);
    wait_rx_settled();
    check_status();
    clear_status();
    check_status();
    pop_byte();
    check_status();

    print_counts();
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verif/uart_status_flags_properties.sv
// bound checks on the uart top: tx_done width, idle line level and FIFO flag consistency
`timescale 1ns/1ps

module uart_status_flags_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              tx_out,
  input logic              tx_idle,
  input logic              tx_done,
  input logic              rx_ready,
  input uart_pkg::status_t status_flags
);

  // done is a single-cycle pulse
  tx_done_single: assert property (@(posedge clk) disable iff (!rst_n)
    tx_done |=> !tx_done)
    else $error("tx_done high for two cycles in a row");

  // idle line is high
  tx_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    tx_idle |-> tx_out)
    else $error("tx_out low while the transmitter is idle");

  fifo_full_empty_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(status_flags.fifo_full && status_flags.fifo_empty))
    else $error("fifo_full and fifo_empty both high");

  rx_ready_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    rx_ready == !status_flags.fifo_empty)
    else $error("rx_ready does not match fifo_empty");

endmodule

bind uart_status_flags uart_status_flags_properties props_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .tx_out       (tx_out),
  .tx_idle      (tx_idle),
  .tx_done      (tx_done),
  .rx_ready     (rx_ready),
  .status_flags (status_flags)
);

//--- verif/tb_clock_gen.sv
// testbench clock and reset source, 8 ns clock with reset held low for ten cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam time half_period = 4;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- source/uart_status_flags.sv
// uart top: transmitter plus receive path of deserializer and FIFO with status outputs
`timescale 1ns/1ps

module uart_status_flags (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        tx_start,
  input  logic [uart_pkg::data_w-1:0] tx_data,
  input  logic                        rx_in,
  input  logic                        rx_pop,
  input  logic                        status_clear,
  output logic                        tx_out,
  output logic                        tx_idle,
  output logic                        tx_done,
  output logic                        rx_idle,
  output logic [uart_pkg::data_w-1:0] rx_data,
  output logic                        rx_ready,
  output logic                        rx_error,
  output uart_pkg::status_t           status_flags
);

  uart_pkg::rx_frame_t rx_frame;
  logic                rx_valid;

  uart_tx tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_out   (tx_out),
    .tx_idle  (tx_idle),
    .tx_done  (tx_done)
  );

  uart_rx rx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_in    (rx_in),
    .rx_frame (rx_frame),
    .rx_valid (rx_valid),
    .rx_idle  (rx_idle)
  );

  // receiver never stalls, the FIFO drops and flags
  uart_rx_fifo fifo_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_frame     (rx_frame),
    .rx_valid     (rx_valid),
    .rx_pop       (rx_pop),
    .status_clear (status_clear),
    .rx_data      (rx_data),
    .rx_ready     (rx_ready),
    .rx_error     (rx_error),
    .status_flags (status_flags)
  );

endmodule

//--- source/uart_rx_fifo.sv
// uart receive FIFO: four-entry fall-through buffer with sticky overrun and break flags
`timescale 1ns/1ps

module uart_rx_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  uart_pkg::rx_frame_t         rx_frame,
  input  logic                        rx_valid,
  input  logic                        rx_pop,
  input  logic                        status_clear,
  output logic [uart_pkg::data_w-1:0] rx_data,
  output logic                        rx_ready,
  output logic                        rx_error,
  output uart_pkg::status_t           status_flags
);

  localparam int ptr_w = $clog2(uart_pkg::fifo_depth);
  localparam int cnt_w = $clog2(uart_pkg::fifo_depth + 1);

  logic [uart_pkg::data_w-1:0] mem [uart_pkg::fifo_depth];
  logic [ptr_w-1:0]            rd_ptr;
  logic [ptr_w-1:0]            wr_ptr;
  logic [cnt_w-1:0]            count;
  logic                        full;
  logic                        empty;
  logic                        push;
  logic                        pop;
  logic                        overrun;
  logic                        brk;

  assign full  = (count == uart_pkg::fifo_depth);
  assign empty = (count == '0);
  // drop on full, ignore pop on empty
  assign push  = rx_valid && !full;
  assign pop   = rx_pop && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= rx_frame.data;
    end
  end

  // sticky flags, a new event beats a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overrun <= 1'b0;
      brk     <= 1'b0;
    end else begin
      if (rx_valid && full) begin
        overrun <= 1'b1;
      end else if (status_clear) begin
        overrun <= 1'b0;
      end
      if (rx_valid && rx_frame.brk) begin
        brk <= 1'b1;
      end else if (status_clear) begin
        brk <= 1'b0;
      end
    end
  end

  assign rx_data  = mem[rd_ptr];
  assign rx_ready = !empty;
  assign rx_error = overrun || brk;

  assign status_flags.fifo_full  = full;
  assign status_flags.fifo_empty = empty;
  assign status_flags.overrun    = overrun;
  assign status_flags.brk        = brk;

endmodule

//--- source/uart_rx.sv
// uart receiver: two-flop synchronizer, one-bit-per-clock deserializer and break detect
`timescale 1ns/1ps

module uart_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx_in,
  output uart_pkg::rx_frame_t rx_frame,
  output logic                rx_valid,
  output logic                rx_idle
);

  localparam int cnt_w = $clog2(uart_pkg::frame_bits);

  logic                      sync1;
  logic                      sync2;
  logic                      line_prev;
  logic                      busy;
  logic [cnt_w-1:0]          cnt;
  logic [uart_pkg::data_w-1:0] shift;
  logic                      start_det;
  logic                      shift_en;
  logic                      stop_en;

  // synchronizer and line history, idle level is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync1     <= 1'b1;
      sync2     <= 1'b1;
      line_prev <= 1'b1;
    end else begin
      sync1     <= rx_in;
      sync2     <= sync1;
      line_prev <= sync2;
    end
  end

  // falling edge on the synced line starts a frame
  assign start_det = !busy && !sync2 && line_prev;
  assign shift_en  = busy && (cnt < uart_pkg::data_w);
  assign stop_en   = busy && (cnt == uart_pkg::data_w);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      cnt      <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (start_det) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (shift_en) begin
        cnt <= cnt + 1'b1;
      end else if (stop_en) begin
        // stop sample, rearm for the next start
        busy     <= 1'b0;
        rx_valid <= 1'b1;
      end
    end
  end

  // data path, lsb arrives first
  always_ff @(posedge clk) begin
    if (shift_en) begin
      shift <= {sync2, shift[uart_pkg::data_w-1:1]};
    end
    if (stop_en) begin
      rx_frame.data <= shift;
      // all-zero byte with a low stop bit
      rx_frame.brk  <= (shift == '0) && !sync2;
    end
  end

  assign rx_idle = !busy;

endmodule

//--- source/uart_tx.sv
// uart transmitter: serializes start, eight data bits lsb first and stop, one bit per clock
`timescale 1ns/1ps

module uart_tx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        tx_start,
  input  logic [uart_pkg::data_w-1:0] tx_data,
  output logic                        tx_out,
  output logic                        tx_idle,
  output logic                        tx_done
);

  localparam int cnt_w = $clog2(uart_pkg::frame_bits);

  logic                        busy;
  logic [cnt_w-1:0]            cnt;
  logic [uart_pkg::data_w-1:0] shift;
  logic                        load;
  logic                        data_phase;

  // starts are only taken between frames
  assign load       = !busy && tx_start;
  assign data_phase = busy && (cnt < uart_pkg::data_w);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      cnt     <= '0;
      tx_out  <= 1'b1;
      tx_done <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (load) begin
        busy   <= 1'b1;
        cnt    <= '0;
        tx_out <= 1'b0;
      end else if (data_phase) begin
        tx_out <= shift[0];
        cnt    <= cnt + 1'b1;
      end else if (busy && cnt == uart_pkg::data_w) begin
        // stop bit
        tx_out <= 1'b1;
        cnt    <= cnt + 1'b1;
      end else if (busy) begin
        // end of stop bit, line stays high
        busy    <= 1'b0;
        tx_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shift <= tx_data;
    end else if (data_phase) begin
      shift <= shift >> 1;
    end
  end

  assign tx_idle = !busy;

endmodule

//--- source/uart_pkg.sv
// uart package: frame and receive FIFO constants plus the shared status and frame structs
package uart_pkg;

  // bits per character
  localparam int data_w = 8;

  // start + data + stop
  localparam int frame_bits = 10;

  // receive FIFO entries
  localparam int fifo_depth = 4;

  // received byte with its break marker
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              brk;
  } rx_frame_t;

  // status word, fifo_full in the MSB
  typedef struct packed {
    logic fifo_full;
    logic fifo_empty;
    logic overrun;
    logic brk;
  } status_t;

endpackage
